// File: logic/rtab_pkg.sv
/*
 * Shared widths and types of the data cache replay table
 * Imported by the blocks that handle requests, dependencies or pop state
 */
`default_nettype none

package rtab_pkg;

    localparam int RTAB_ADDR_W      = 32;
    localparam int RTAB_CL_OFFSET_W = 6;
    localparam int RTAB_NLINE_W     = RTAB_ADDR_W - RTAB_CL_OFFSET_W;

    typedef logic [RTAB_ADDR_W-1:0]  rtab_addr_t;
    typedef logic [RTAB_NLINE_W-1:0] rtab_nline_t;

    typedef enum logic [1:0] {
        LOAD,
        STORE,
        AMO,
        PREFETCH
    } rtab_op_e;

    // Request as parked in the table
    typedef struct packed {
        rtab_op_e   op;
        rtab_addr_t addr;
        logic [7:0] tid;
    } rtab_req_t;

    // Reasons a request cannot be replayed yet
    typedef struct packed {
        logic mshr_hit;
        logic mshr_full;
        logic miss_not_ready;
    } rtab_deps_t;

    // Link is set when the request joins the list of its cache line
    typedef struct packed {
        rtab_req_t  req;
        rtab_deps_t deps;
        logic       link;
    } rtab_alloc_t;

    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_NEXT_WAIT
    } rtab_pop_state_e;

    function automatic rtab_nline_t rtab_nline_of(input rtab_addr_t addr);
        return addr[RTAB_CL_OFFSET_W +: RTAB_NLINE_W];
    endfunction

endpackage

`default_nettype wire

// File: logic/rtab_rr_arbiter.sv
/*
 * Round-robin arbiter with a one-hot grant
 * The priority pointer moves past the winner only when advance_i is high
 */
`timescale 1ns/100ps
`default_nettype none

module rtab_rr_arbiter #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [NUM_ENTRIES-1:0] req_i,
    input  logic                   advance_i,
    output logic [NUM_ENTRIES-1:0] gnt_o
);

    localparam int PTR_W = $clog2(NUM_ENTRIES);

    logic [PTR_W-1:0] prio_q;
    logic [PTR_W-1:0] gnt_idx;

    // Scan from the farthest offset so the closest requester wins
    always_comb begin
        int idx;
        gnt_o   = '0;
        gnt_idx = '0;
        for (int off = NUM_ENTRIES - 1; off >= 0; off--) begin
            idx = (int'(prio_q) + off) % NUM_ENTRIES;
            if (req_i[idx]) begin
                gnt_o      = '0;
                gnt_o[idx] = 1'b1;
                gnt_idx    = PTR_W'(idx);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= '0;
        end else if (advance_i && |req_i) begin
            prio_q <= (gnt_idx == PTR_W'(NUM_ENTRIES - 1)) ? '0 : gnt_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/rtab_entry_store.sv
/*
 * Entry array of the replay table with list bookkeeping
 * Allocates the lowest free entry and links same-line requests in arrival order
 */
`timescale 1ns/100ps
`default_nettype none

module rtab_entry_store
    import rtab_pkg::*;
#(
    parameter int NUM_ENTRIES = 8,
    localparam int PTR_W = $clog2(NUM_ENTRIES)
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                alloc_fire_i,
    input  rtab_alloc_t                         alloc_i,
    input  rtab_nline_t                         check_nline_i,
    input  logic [NUM_ENTRIES-1:0]              taken_i,
    input  logic                                commit_i,
    input  logic [PTR_W-1:0]                    commit_ptr_i,
    input  logic                                rback_i,
    input  logic [PTR_W-1:0]                    rback_ptr_i,
    output logic                                check_hit_o,
    output logic [NUM_ENTRIES-1:0]              valid_o,
    output logic [NUM_ENTRIES-1:0]              head_o,
    output logic [NUM_ENTRIES-1:0]              tail_o,
    output logic [NUM_ENTRIES-1:0][PTR_W-1:0]   next_o,
    output rtab_nline_t [NUM_ENTRIES-1:0]       nline_o,
    output rtab_req_t [NUM_ENTRIES-1:0]         req_o,
    output logic [NUM_ENTRIES-1:0]              alloc_sel_o,
    output logic                                full_o,
    output logic                                fence_o
);

    logic [NUM_ENTRIES-1:0]            valid_q;
    logic [NUM_ENTRIES-1:0]            head_q;
    logic [NUM_ENTRIES-1:0]            tail_q;
    logic [NUM_ENTRIES-1:0][PTR_W-1:0] next_q;
    rtab_req_t [NUM_ENTRIES-1:0]       req_q;

    logic [NUM_ENTRIES-1:0] free_first;
    logic [PTR_W-1:0]       alloc_ptr;
    logic [NUM_ENTRIES-1:0] link_tail;
    logic [NUM_ENTRIES-1:0] commit_sel;
    logic [NUM_ENTRIES-1:0] rback_sel;
    logic [NUM_ENTRIES-1:0] check_match;
    logic [NUM_ENTRIES-1:0] is_amo;
    rtab_nline_t            alloc_nline;

    assign alloc_nline = rtab_nline_of(alloc_i.req.addr);

    // Lowest free entry
    always_comb begin
        free_first = '0;
        alloc_ptr  = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_first    = '0;
                free_first[i] = 1'b1;
                alloc_ptr     = PTR_W'(i);
            end
        end
    end

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
        assign nline_o[i]     = rtab_nline_of(req_q[i].addr);
        assign check_match[i] = valid_q[i] && (nline_o[i] == check_nline_i);
        assign is_amo[i]      = valid_q[i] && (req_q[i].op == AMO);
        // Old tail of the line that the new request joins
        assign link_tail[i]   = alloc_fire_i && alloc_i.link && valid_q[i] && tail_q[i]
                                && (nline_o[i] == alloc_nline);
        assign commit_sel[i]  = commit_i && (commit_ptr_i == PTR_W'(i));
        assign rback_sel[i]   = rback_i && (rback_ptr_i == PTR_W'(i));
    end

    assign alloc_sel_o = free_first & {NUM_ENTRIES{alloc_fire_i}};
    assign check_hit_o = |check_match;
    assign fence_o     = |is_amo;
    assign full_o      = &valid_q;
    assign valid_o     = valid_q;
    assign head_o      = head_q;
    assign tail_o      = tail_q;
    assign next_o      = next_q;
    assign req_o       = req_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            next_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_sel_o) & ~commit_sel;
            // A popped entry leaves the head set until it is rolled back
            head_q  <= (head_q & ~taken_i & ~alloc_sel_o) | rback_sel
                       | (alloc_sel_o & {NUM_ENTRIES{!alloc_i.link}});
            tail_q  <= (tail_q & ~link_tail) | alloc_sel_o;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (link_tail[i]) begin
                    next_q[i] <= alloc_ptr;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (alloc_sel_o[i]) begin
                req_q[i] <= alloc_i.req;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rtab_dep_tracker.sv
/*
 * Per-entry dependency and error flags of the replay table
 * Flags load on allocation or rollback and clear on refill and miss-ready events
 */
`timescale 1ns/100ps
`default_nettype none

module rtab_dep_tracker
    import rtab_pkg::*;
#(
    parameter int NUM_ENTRIES = 8,
    localparam int PTR_W = $clog2(NUM_ENTRIES)
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic [NUM_ENTRIES-1:0]        alloc_sel_i,
    input  rtab_deps_t                    alloc_deps_i,
    input  logic                          rback_i,
    input  logic [PTR_W-1:0]              rback_ptr_i,
    input  rtab_deps_t                    rback_deps_i,
    input  logic [NUM_ENTRIES-1:0]        valid_i,
    input  rtab_nline_t [NUM_ENTRIES-1:0] nline_i,
    input  logic                          refill_valid_i,
    input  rtab_nline_t                   refill_nline_i,
    input  logic                          refill_error_i,
    input  logic                          miss_ready_i,
    output logic [NUM_ENTRIES-1:0]        blocked_o,
    output logic [NUM_ENTRIES-1:0]        error_o
);

    rtab_deps_t [NUM_ENTRIES-1:0] deps_q;
    logic [NUM_ENTRIES-1:0]       error_q;
    logic [NUM_ENTRIES-1:0]       refill_hit;
    logic [NUM_ENTRIES-1:0]       rback_sel;

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_match
        assign refill_hit[i] = refill_valid_i && (nline_i[i] == refill_nline_i);
        assign rback_sel[i]  = rback_i && (rback_ptr_i == PTR_W'(i));
        assign blocked_o[i]  = |deps_q[i];
    end

    assign error_o = error_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            deps_q  <= '0;
            error_q <= '0;
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (alloc_sel_i[i]) begin
                    deps_q[i]  <= alloc_deps_i;
                    error_q[i] <= 1'b0;
                end else if (rback_sel[i]) begin
                    deps_q[i] <= rback_deps_i;
                end else begin
                    // Only a refill of the same line releases a pending miss
                    if (refill_hit[i]) begin
                        deps_q[i].mshr_hit <= 1'b0;
                    end
                    // Any refill frees a miss table slot
                    if (refill_valid_i) begin
                        deps_q[i].mshr_full <= 1'b0;
                    end
                    if (miss_ready_i) begin
                        deps_q[i].miss_not_ready <= 1'b0;
                    end
                    if (refill_hit[i] && refill_error_i && valid_i[i] && deps_q[i].mshr_hit) begin
                        error_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rtab_pop_sequencer.sv
/*
 * Pop FSM of the replay table
 * Picks a ready list head round-robin, then walks the rest of its list
 */
`timescale 1ns/100ps
`default_nettype none

module rtab_pop_sequencer
    import rtab_pkg::*;
#(
    parameter int NUM_ENTRIES = 8,
    localparam int PTR_W = $clog2(NUM_ENTRIES)
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic [NUM_ENTRIES-1:0]            valid_i,
    input  logic [NUM_ENTRIES-1:0]            head_i,
    input  logic [NUM_ENTRIES-1:0]            tail_i,
    input  logic [NUM_ENTRIES-1:0][PTR_W-1:0] next_i,
    input  logic [NUM_ENTRIES-1:0]            blocked_i,
    input  logic [NUM_ENTRIES-1:0]            error_i,
    input  rtab_req_t [NUM_ENTRIES-1:0]       req_i,
    input  logic                              pop_ready_i,
    input  logic                              rback_i,
    output logic                              pop_valid_o,
    output rtab_req_t                         pop_req_o,
    output logic [PTR_W-1:0]                  pop_ptr_o,
    output logic                              pop_error_o,
    output logic [NUM_ENTRIES-1:0]            taken_o
);

    rtab_pop_state_e        state_q, state_d;
    logic [PTR_W-1:0]       walk_q, walk_d;
    logic [NUM_ENTRIES-1:0] ready;
    logic [NUM_ENTRIES-1:0] gnt;
    logic [PTR_W-1:0]       gnt_ptr;
    logic [PTR_W-1:0]       sel_ptr;
    logic                   accept;
    logic                   head_accept;

    assign ready = valid_i & head_i & ~blocked_i;

    rtab_rr_arbiter #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_head_arb (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (ready),
        .advance_i (head_accept),
        .gnt_o     (gnt)
    );

    always_comb begin
        gnt_ptr = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (gnt[i]) begin
                gnt_ptr = PTR_W'(i);
            end
        end
    end

    // While walking a list the next entry is offered whatever its flags
    assign sel_ptr     = (state_q == POP_HEAD) ? gnt_ptr : walk_q;
    assign pop_valid_o = (state_q == POP_HEAD) ? |ready : 1'b1;
    assign accept      = pop_valid_o && pop_ready_i;
    assign head_accept = accept && (state_q == POP_HEAD);

    assign pop_ptr_o   = sel_ptr;
    assign pop_req_o   = req_i[sel_ptr];
    assign pop_error_o = error_i[sel_ptr];

    always_comb begin
        taken_o          = '0;
        taken_o[sel_ptr] = accept;
    end

    always_comb begin
        state_d = state_q;
        walk_d  = walk_q;
        case (state_q)
            POP_HEAD: begin
                if (accept && !tail_i[sel_ptr]) begin
                    state_d = POP_NEXT;
                    walk_d  = next_i[sel_ptr];
                end
            end
            POP_NEXT, POP_NEXT_WAIT: begin
                if (rback_i) begin
                    state_d = POP_HEAD;
                end else if (accept) begin
                    state_d = tail_i[sel_ptr] ? POP_HEAD : POP_NEXT;
                    walk_d  = next_i[sel_ptr];
                end else begin
                    state_d = POP_NEXT_WAIT;
                end
            end
            default: state_d = POP_HEAD;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POP_HEAD;
            walk_q  <= '0;
        end else begin
            state_q <= state_d;
            walk_q  <= walk_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/rtab_top.sv
/*
 * Replay table for a non-blocking data cache
 * Parks blocked requests per cache line and offers ready ones for replay
 */
`timescale 1ns/100ps
`default_nettype none

module rtab_top
    import rtab_pkg::*;
#(
    parameter int NUM_ENTRIES = 8,
    localparam int PTR_W = $clog2(NUM_ENTRIES)
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             alloc_valid_i,
    output logic             alloc_ready_o,
    input  rtab_alloc_t      alloc_i,
    input  rtab_nline_t      check_nline_i,
    output logic             check_hit_o,
    output logic             pop_valid_o,
    input  logic             pop_ready_i,
    output rtab_req_t        pop_req_o,
    output logic [PTR_W-1:0] pop_ptr_o,
    output logic             pop_error_o,
    input  logic             commit_i,
    input  logic [PTR_W-1:0] commit_ptr_i,
    input  logic             rback_i,
    input  logic [PTR_W-1:0] rback_ptr_i,
    input  rtab_deps_t       rback_deps_i,
    input  logic             refill_valid_i,
    input  rtab_nline_t      refill_nline_i,
    input  logic             refill_error_i,
    input  logic             miss_ready_i,
    output logic             empty_o,
    output logic             fence_o
);

    logic [NUM_ENTRIES-1:0]            valid;
    logic [NUM_ENTRIES-1:0]            head;
    logic [NUM_ENTRIES-1:0]            tail;
    logic [NUM_ENTRIES-1:0][PTR_W-1:0] next;
    rtab_nline_t [NUM_ENTRIES-1:0]     nline;
    rtab_req_t [NUM_ENTRIES-1:0]       req;
    logic [NUM_ENTRIES-1:0]            alloc_sel;
    logic [NUM_ENTRIES-1:0]            taken;
    logic [NUM_ENTRIES-1:0]            blocked;
    logic [NUM_ENTRIES-1:0]            error;
    logic                              full;
    logic                              alloc_fire;

    assign alloc_ready_o = !full;
    assign alloc_fire    = alloc_valid_i && alloc_ready_o;
    assign empty_o       = ~|valid;

    rtab_entry_store #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_store (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_fire_i  (alloc_fire),
        .alloc_i       (alloc_i),
        .check_nline_i (check_nline_i),
        .taken_i       (taken),
        .commit_i      (commit_i),
        .commit_ptr_i  (commit_ptr_i),
        .rback_i       (rback_i),
        .rback_ptr_i   (rback_ptr_i),
        .check_hit_o   (check_hit_o),
        .valid_o       (valid),
        .head_o        (head),
        .tail_o        (tail),
        .next_o        (next),
        .nline_o       (nline),
        .req_o         (req),
        .alloc_sel_o   (alloc_sel),
        .full_o        (full),
        .fence_o       (fence_o)
    );

    rtab_dep_tracker #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_deps (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .alloc_sel_i    (alloc_sel),
        .alloc_deps_i   (alloc_i.deps),
        .rback_i        (rback_i),
        .rback_ptr_i    (rback_ptr_i),
        .rback_deps_i   (rback_deps_i),
        .valid_i        (valid),
        .nline_i        (nline),
        .refill_valid_i (refill_valid_i),
        .refill_nline_i (refill_nline_i),
        .refill_error_i (refill_error_i),
        .miss_ready_i   (miss_ready_i),
        .blocked_o      (blocked),
        .error_o        (error)
    );

    rtab_pop_sequencer #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_pop (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (valid),
        .head_i      (head),
        .tail_i      (tail),
        .next_i      (next),
        .blocked_i   (blocked),
        .error_i     (error),
        .req_i       (req),
        .pop_ready_i (pop_ready_i),
        .rback_i     (rback_i),
        .pop_valid_o (pop_valid_o),
        .pop_req_o   (pop_req_o),
        .pop_ptr_o   (pop_ptr_o),
        .pop_error_o (pop_error_o),
        .taken_o     (taken)
    );

endmodule

`default_nettype wire

// File: verification/rtab_tb.sv
/*
 * Testbench for the replay table top level
 * Drives allocation, pop, commit, rollback and refill traffic and checks with assertions
 */
`timescale 1ns/100ps
`default_nettype none

module rtab_tb
    import rtab_pkg::*;
();

    localparam int NUM_ENTRIES = 8;
    localparam int PTR_W       = $clog2(NUM_ENTRIES);
    localparam int TIMEOUT     = 200;

    logic             clk_i = 1'b0;
    logic             rst_ni;
    logic             alloc_valid_i;
    logic             alloc_ready_o;
    rtab_alloc_t      alloc_i;
    rtab_nline_t      check_nline_i;
    logic             check_hit_o;
    logic             pop_valid_o;
    logic             pop_ready_i;
    rtab_req_t        pop_req_o;
    logic [PTR_W-1:0] pop_ptr_o;
    logic             pop_error_o;
    logic             commit_i;
    logic [PTR_W-1:0] commit_ptr_i;
    logic             rback_i;
    logic [PTR_W-1:0] rback_ptr_i;
    rtab_deps_t       rback_deps_i;
    logic             refill_valid_i;
    rtab_nline_t      refill_nline_i;
    logic             refill_error_i;
    logic             miss_ready_i;
    logic             empty_o;
    logic             fence_o;

    // Reference model, indexed by transaction id
    logic             parked [256];
    logic             blocked_tid [256];
    logic             err_tid [256];
    rtab_req_t        exp_req [256];
    logic [PTR_W-1:0] exp_ptr [256];
    // Entry occupancy, the lowest free entry takes the next request
    logic             slot_busy [NUM_ENTRIES];
    logic [7:0]       order_q [$];
    logic             hold_check = 1'b0;
    logic [31:0]      rng_state = 32'h422c_e9f3;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;

    rtab_top #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) dut (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic rtab_nline_t line_of(input rtab_addr_t addr);
        return addr[RTAB_ADDR_W-1:RTAB_CL_OFFSET_W];
    endfunction

    function automatic rtab_req_t rand_req(input rtab_op_e op, input logic [7:0] tid);
        rtab_req_t r;
        r.op   = op;
        r.addr = next_rand();
        r.tid  = tid;
        return r;
    endfunction

    function automatic rtab_deps_t make_deps(input logic hit, input logic full, input logic nr);
        rtab_deps_t d;
        d.mshr_hit       = hit;
        d.mshr_full      = full;
        d.miss_not_ready = nr;
        return d;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR @ %0d ns: %s", $time, msg);
    endtask

    task automatic give_up(input string msg);
        $display("Timeout: %s", msg);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic alloc_req(input rtab_req_t req, input rtab_deps_t deps, input logic link);
        int cnt;
        int slot;
        cnt = 0;
        while (!alloc_ready_o && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (!alloc_ready_o) begin
            give_up("the table never accepted an allocation");
        end else begin
            alloc_valid_i        = 1'b1;
            alloc_i.req          = req;
            alloc_i.deps         = deps;
            alloc_i.link         = link;
            parked[req.tid]      = 1'b1;
            exp_req[req.tid]     = req;
            blocked_tid[req.tid] = |deps;
            err_tid[req.tid]     = 1'b0;
            slot = 0;
            while (slot < NUM_ENTRIES - 1 && slot_busy[slot]) begin
                slot++;
            end
            slot_busy[slot]  = 1'b1;
            exp_ptr[req.tid] = PTR_W'(slot);
            @(negedge clk_i);
            alloc_valid_i = 1'b0;
        end
    endtask

    // Waits for an offer, checks it against the model and accepts it
    task automatic pop_take(output logic [PTR_W-1:0] ptr, output rtab_req_t req,
                            output logic err);
        int cnt;
        cnt = 0;
        while (!pop_valid_o && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (!pop_valid_o) begin
            give_up("no request was offered for replay");
        end else begin
            ptr = pop_ptr_o;
            req = pop_req_o;
            err = pop_error_o;
            assert (parked[req.tid] && req == exp_req[req.tid])
            else flag_error($sformatf("offered tid %0h is not parked or differs", req.tid));
            assert (ptr == exp_ptr[req.tid])
            else flag_error($sformatf("tid %0h offered from entry %0d", req.tid, ptr));
            parked[req.tid] = 1'b0;
            pop_ready_i     = 1'b1;
            @(negedge clk_i);
            pop_ready_i = 1'b0;
        end
    endtask

    task automatic commit_entry(input logic [PTR_W-1:0] ptr);
        slot_busy[ptr] = 1'b0;
        commit_i       = 1'b1;
        commit_ptr_i   = ptr;
        @(negedge clk_i);
        commit_i = 1'b0;
    endtask

    task automatic roll_back(input logic [PTR_W-1:0] ptr, input rtab_deps_t deps);
        rback_i      = 1'b1;
        rback_ptr_i  = ptr;
        rback_deps_i = deps;
        @(negedge clk_i);
        rback_i = 1'b0;
    endtask

    task automatic send_refill(input rtab_nline_t line, input logic error);
        refill_valid_i = 1'b1;
        refill_nline_i = line;
        refill_error_i = error;
        @(negedge clk_i);
        refill_valid_i = 1'b0;
        refill_error_i = 1'b0;
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            assert (!pop_valid_o) else flag_error("a blocked request was offered for replay");
        end
    endtask

    assert property (@(posedge clk_i) !rst_ni |->
                     empty_o && alloc_ready_o && !pop_valid_o && !fence_o)
    else flag_error("outputs differ from the reset state");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     pop_valid_o |-> !blocked_tid[pop_req_o.tid])
    else flag_error($sformatf("tid %0h offered while still blocked", pop_req_o.tid));

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     pop_valid_o |-> pop_error_o == err_tid[pop_req_o.tid])
    else flag_error($sformatf("pop_error_o wrong for tid %0h", pop_req_o.tid));

    // A walked entry must stay offered unchanged under back-pressure
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     hold_check && pop_valid_o && !pop_ready_i
                     |=> pop_valid_o && $stable(pop_req_o))
    else flag_error("offered request changed while pop_ready_i was low");

    initial begin
        rtab_req_t        req;
        rtab_req_t        first;
        logic [PTR_W-1:0] ptr;
        logic [PTR_W-1:0] prev_ptr;
        logic             err;
        logic [7:0]       exp_tid;
        logic [31:0]      r;
        rtab_nline_t      line;
        rtab_op_e         op;
        logic             amo_done;
        int               mark;

        rst_ni         = 1'b1;
        alloc_valid_i  = 1'b0;
        alloc_i        = '0;
        check_nline_i  = '0;
        pop_ready_i    = 1'b0;
        commit_i       = 1'b0;
        commit_ptr_i   = '0;
        rback_i        = 1'b0;
        rback_ptr_i    = '0;
        rback_deps_i   = '0;
        refill_valid_i = 1'b0;
        refill_nline_i = '0;
        refill_error_i = 1'b0;
        miss_ready_i   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            parked[i]      = 1'b0;
            blocked_tid[i] = 1'b0;
            err_tid[i]     = 1'b0;
            exp_req[i]     = '0;
            exp_ptr[i]     = '0;
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            slot_busy[i] = 1'b0;
        end

        #1 rst_ni = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        mark = errors;
        @(negedge clk_i);
        assert (empty_o && alloc_ready_o && !pop_valid_o && !fence_o)
        else flag_error("state after reset is not idle and empty");
        finish_test("reset", mark);

        mark = errors;
        alloc_req(rand_req(LOAD, 8'h10), make_deps(0, 0, 0), 1'b0);
        pop_take(ptr, req, err);
        assert (req.tid == 8'h10 && !err) else flag_error("single entry offered wrongly");
        commit_entry(ptr);
        assert (empty_o) else flag_error("table not empty after commit");
        finish_test("single_entry", mark);

        // Three requests on one line, linked in arrival order
        mark  = errors;
        first = rand_req(STORE, 8'h20);
        line  = line_of(first.addr);
        check_nline_i = line;
        alloc_req(first, make_deps(0, 0, 0), 1'b0);
        order_q.push_back(8'h20);
        assert (check_hit_o) else flag_error("check_hit_o low for a parked line");
        for (int i = 1; i < 3; i++) begin
            r = next_rand();
            req.op   = LOAD;
            req.addr = {line, r[5:0]};
            req.tid  = 8'(8'h20 + i);
            alloc_req(req, make_deps(0, 0, 0), 1'b1);
            order_q.push_back(req.tid);
        end
        for (int i = 0; i < 3; i++) begin
            pop_take(ptr, req, err);
            exp_tid = order_q.pop_front();
            assert (req.tid == exp_tid)
            else flag_error($sformatf("popped tid %0h, expected %0h", req.tid, exp_tid));
            hold_check = (i == 0);
            if (i == 0) begin
                assert (pop_valid_o && pop_req_o == exp_req[order_q[0]])
                else flag_error("next list entry not offered right after its head");
            end
            commit_entry(ptr);
            if (i == 0) begin
                repeat (2) begin
                    assert (pop_valid_o && pop_req_o == exp_req[order_q[0]])
                    else flag_error("next list entry not held under back-pressure");
                    @(negedge clk_i);
                end
                hold_check = 1'b0;
            end
            assert (check_hit_o == (i < 2)) else flag_error("check_hit_o wrong during drain");
        end
        finish_test("list_order", mark);

        // Pending miss on one line and a full miss table
        mark = errors;
        req  = rand_req(LOAD, 8'h30);
        line = line_of(req.addr);
        alloc_req(req, make_deps(1, 0, 0), 1'b0);
        alloc_req(rand_req(STORE, 8'h31), make_deps(0, 1, 0), 1'b0);
        expect_idle(4);
        send_refill(line ^ rtab_nline_t'(1), 1'b0);
        blocked_tid[8'h31] = 1'b0;
        pop_take(ptr, req, err);
        assert (req.tid == 8'h31) else flag_error("any refill did not release mshr_full");
        commit_entry(ptr);
        expect_idle(4);
        send_refill(line, 1'b1);
        blocked_tid[8'h30] = 1'b0;
        err_tid[8'h30]     = 1'b1;
        pop_take(ptr, req, err);
        assert (req.tid == 8'h30 && err) else flag_error("erroring refill not reported");
        commit_entry(ptr);
        finish_test("dependencies", mark);

        mark = errors;
        alloc_req(rand_req(LOAD, 8'h40), make_deps(0, 0, 0), 1'b0);
        pop_take(ptr, req, err);
        parked[8'h40]      = 1'b1;
        blocked_tid[8'h40] = 1'b1;
        roll_back(ptr, make_deps(0, 0, 1));
        expect_idle(5);
        miss_ready_i = 1'b1;
        @(negedge clk_i);
        miss_ready_i       = 1'b0;
        blocked_tid[8'h40] = 1'b0;
        pop_take(ptr, req, err);
        assert (req.tid == 8'h40) else flag_error("rolled back entry not offered again");
        commit_entry(ptr);
        finish_test("rollback", mark);

        // Fill the table with one AMO among random requests, then drain it
        mark = errors;
        assert (empty_o) else flag_error("table not empty before the capacity test");
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            r  = next_rand();
            op = (i == 3) ? AMO : ((r[1:0] == 2'd2) ? PREFETCH : (r[0] ? STORE : LOAD));
            alloc_req(rand_req(op, 8'(8'h50 + i)), make_deps(0, 0, 0), 1'b0);
        end
        assert (!alloc_ready_o && fence_o) else flag_error("full table not reported");
        amo_done = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            pop_take(ptr, req, err);
            if (i == 0) begin
                // A head put back at once waits behind the next head in round-robin order
                parked[req.tid] = 1'b1;
                roll_back(ptr, make_deps(0, 0, 0));
                prev_ptr = ptr;
                pop_take(ptr, req, err);
                assert (ptr == PTR_W'((int'(prev_ptr) + 1) % NUM_ENTRIES))
                else flag_error("round-robin did not move past the previous head");
            end
            commit_entry(ptr);
            if (req.op == AMO) begin
                amo_done = 1'b1;
            end
            assert (fence_o == !amo_done) else flag_error("fence_o wrong during drain");
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            assert (!parked[8'h50 + i]) else flag_error("a parked id was never popped");
        end
        assert (empty_o && alloc_ready_o) else flag_error("table not empty after drain");
        finish_test("capacity", mark);

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtab.f
logic/rtab_pkg.sv
logic/rtab_rr_arbiter.sv
logic/rtab_entry_store.sv
logic/rtab_dep_tracker.sv
logic/rtab_pop_sequencer.sv
logic/rtab_top.sv
verification/rtab_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the replay table testbench with Verilator and run it
# The run counts as passed only if the log holds the pass line
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

rm -rf "${BUILD_DIR}" "${LOG_FILE}"

verilator --binary --timing --assert \
    --top-module rtab_tb \
    --Mdir "${BUILD_DIR}" \
    -o rtab_sim \
    -f rtab.f

"./${BUILD_DIR}/rtab_sim" | tee "${LOG_FILE}"

if grep -qx '>>> PASS' "${LOG_FILE}"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
